// File: design/bnd_consts.svh
`ifndef BND_CONSTS_SVH
`define BND_CONSTS_SVH

// dimensions per hypervector, one counter each
`define BND_HV_DIM 16

// items carried per beat, one bit per item
`define BND_VOTE_W 32

// signed accumulator width, covers +/-256
`define BND_ACC_W 10

// largest item count per run
`define BND_MAX_ITEMS 255

// tie-break generator, value after reset and Galois feedback mask
`define BND_LFSR_SEED 16'hACE1
`define BND_LFSR_TAPS 16'hB400

`endif

// File: design/hdc_types_pkg.sv
`include "bnd_consts.svh"

package hdc_types_pkg;

    // one bit per dimension
    typedef logic [`BND_HV_DIM-1:0] hv_t;

    // bit k is item k's bit for one dimension
    typedef logic [`BND_VOTE_W-1:0] vote_word_t;

    // +1, -1 or 0 for a masked item
    typedef logic signed [1:0] vote_t;

    // running signed count of one dimension
    typedef logic signed [`BND_ACC_W-1:0] acc_t;

    // one vote word per dimension, bit-sliced beat
    typedef vote_word_t [`BND_HV_DIM-1:0] vote_bus_t;

endpackage

// File: design/bundle_ctrl_pkg.sv
`include "bnd_consts.svh"

package bundle_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        FINISH
    } ctrl_state_t;

    typedef logic [$clog2(`BND_MAX_ITEMS + 1)-1:0] item_count_t;

    // 0 means the whole last word is valid
    typedef logic [$clog2(`BND_VOTE_W)-1:0] remainder_t;

endpackage

// File: design/bundle_ctrl_if.sv
`timescale 1ns/10ps

interface bundle_ctrl_if (
    input logic clk
);
    import hdc_types_pkg::*;
    import bundle_ctrl_pkg::*;

    // start of run, with parity and tie vector
    logic       init;
    logic       even;
    hv_t        tie;

    // one pulse per accepted beat
    logic       update;
    logic       last;
    remainder_t remainder;

    modport bundle_ctrl (
        input  clk,
        output init, even, tie, update, last, remainder
    );

    modport counter (
        input clk,
        input init, even, tie, update, last, remainder
    );

endinterface

// File: design/bundle_ctrl.sv
`timescale 1ns/10ps
`include "bnd_consts.svh"

module bundle_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  bundle_ctrl_pkg::item_count_t item_count,
    input  logic                         vote_valid,
    output logic                         busy,
    output logic                         capture,
    bundle_ctrl_if.bundle_ctrl           ctl
);
    import hdc_types_pkg::*;
    import bundle_ctrl_pkg::*;

    localparam int SHIFT  = $clog2(`BND_VOTE_W);
    localparam int CNT_W  = $bits(item_count_t) + 1;
    localparam int BEAT_W = $clog2(`BND_MAX_ITEMS / `BND_VOTE_W + 2);

    ctrl_state_t       state;
    logic [BEAT_W-1:0] beats_left;
    logic [BEAT_W-1:0] beats_load;
    logic [CNT_W-1:0]  count_round;
    remainder_t        rem_q;
    hv_t               lfsr;
    hv_t               lfsr_next;
    logic              accept;
    logic              update;
    logic              last;

    // a run needs at least one item
    assign accept = (state == IDLE) && start && (item_count != '0);

    // beats per run, rounded up to whole vote words
    assign count_round = {1'b0, item_count} + CNT_W'(`BND_VOTE_W - 1);
    assign beats_load  = BEAT_W'(count_round >> SHIFT);

    // right-shifting Galois step
    assign lfsr_next = (lfsr >> 1) ^ ({$bits(hv_t){lfsr[0]}} & `BND_LFSR_TAPS);

    assign update = (state == ACCUM) && vote_valid;
    assign last   = update && (beats_left == BEAT_W'(1));

    // counters load their bias on the accepting edge
    assign ctl.init      = accept;
    assign ctl.even      = ~item_count[0];
    assign ctl.tie       = lfsr_next;
    assign ctl.update    = update;
    assign ctl.last      = last;
    assign ctl.remainder = rem_q;

    assign busy    = (state != IDLE);
    assign capture = (state == FINISH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            beats_left <= '0;
            rem_q      <= '0;
            lfsr       <= `BND_LFSR_SEED;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state      <= ACCUM;
                        beats_left <= beats_load;
                        rem_q      <= remainder_t'(item_count);
                        // one step per accepted start
                        lfsr       <= lfsr_next;
                    end
                end
                ACCUM: begin
                    if (update) begin
                        beats_left <= beats_left - BEAT_W'(1);
                        if (last) begin
                            state <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    // collector latches the signs on this edge
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/vote_counter.sv
`timescale 1ns/10ps
`include "bnd_consts.svh"

module vote_counter (
    input  logic                      clk,
    input  logic                      rst,
    bundle_ctrl_if.counter            ctl,
    input  logic                      tie_bit,
    input  hdc_types_pkg::vote_word_t votes,
    output logic                      sign
);
    import hdc_types_pkg::*;

    localparam vote_t VOTE_UP   = 2'sb01;
    localparam vote_t VOTE_DOWN = 2'sb11;
    localparam vote_t VOTE_NONE = 2'sb00;
    localparam acc_t  BIAS_UP   = acc_t'(1);
    localparam acc_t  BIAS_DOWN = acc_t'(-1);

    vote_t sel [`BND_VOTE_W];
    acc_t  beat_sum;
    acc_t  bias;
    acc_t  acc;

    // per-item vote, masked above the remainder on the last beat
    always_comb begin
        for (int k = 0; k < `BND_VOTE_W; k++) begin
            if (ctl.last && (ctl.remainder != '0) && (k >= int'(ctl.remainder))) begin
                sel[k] = VOTE_NONE;
            end else begin
                sel[k] = votes[k] ? VOTE_UP : VOTE_DOWN;
            end
        end
    end

    // adder tree left to synthesis
    always_comb begin
        beat_sum = '0;
        for (int k = 0; k < `BND_VOTE_W; k++) begin
            beat_sum = beat_sum + acc_t'(sel[k]);
        end
    end

    // even count starts off zero so the total can never tie
    assign bias = ctl.even ? (tie_bit ? BIAS_DOWN : BIAS_UP) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (ctl.init) begin
            acc <= bias;
        end else if (ctl.update) begin
            acc <= acc + beat_sum;
        end
    end

    // negative count means the 0 votes won
    assign sign = acc[`BND_ACC_W-1];

endmodule

// File: design/sign_collector.sv
`timescale 1ns/10ps

module sign_collector (
    input  logic                clk,
    input  logic                rst,
    input  logic                capture,
    input  hdc_types_pkg::hv_t  signs,
    output hdc_types_pkg::hv_t  hv_out,
    output logic                done
);
    import hdc_types_pkg::*;

    hv_t majority;

    // a clear sign bit means the 1 votes won
    assign majority = ~signs;

    always_ff @(posedge clk) begin
        if (rst) begin
            hv_out <= '0;
            done   <= 1'b0;
        end else begin
            done <= capture;
            if (capture) begin
                hv_out <= majority;
            end
        end
    end

endmodule

// File: design/hv_bundler.sv
`timescale 1ns/10ps
`include "bnd_consts.svh"

module hv_bundler (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  bundle_ctrl_pkg::item_count_t item_count,
    input  logic                         vote_valid,
    input  hdc_types_pkg::vote_bus_t     votes,
    output logic                         busy,
    output logic                         done,
    output hdc_types_pkg::hv_t           hv_out
);
    import hdc_types_pkg::*;

    hv_t  signs;
    logic capture;

    // strobes shared by every counter
    bundle_ctrl_if ctl_if (
        .clk (clk)
    );

    bundle_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .item_count (item_count),
        .vote_valid (vote_valid),
        .busy       (busy),
        .capture    (capture),
        .ctl        (ctl_if)
    );

    // one counter per dimension, each with its own tie bit
    for (genvar d = 0; d < `BND_HV_DIM; d++) begin : g_dim
        vote_counter counter_i (
            .clk     (clk),
            .rst     (rst),
            .ctl     (ctl_if),
            .tie_bit (ctl_if.tie[d]),
            .votes   (votes[d]),
            .sign    (signs[d])
        );
    end

    sign_collector collect_i (
        .clk     (clk),
        .rst     (rst),
        .capture (capture),
        .signs   (signs),
        .hv_out  (hv_out),
        .done    (done)
    );

endmodule

// File: bench/hv_bundler_asserts.sv
`timescale 1ns/10ps

module hv_bundler_asserts (
    input logic                        clk,
    input logic                        rst,
    input bundle_ctrl_pkg::ctrl_state_t state,
    input logic                        init,
    input logic                        update,
    input logic                        last,
    input logic                        capture,
    input logic                        done
);
    import bundle_ctrl_pkg::*;

    // beats are only counted while accumulating
    update_in_accum: assert property (@(posedge clk) disable iff (rst)
        update |-> (state == ACCUM))
        else $error("update pulsed outside ACCUM");

    last_with_update: assert property (@(posedge clk) disable iff (rst)
        last |-> update)
        else $error("last pulsed without update");

    // bias is loaded once per run
    init_one_cycle: assert property (@(posedge clk) disable iff (rst)
        init |=> !init)
        else $error("init held longer than one cycle");

    done_after_capture: assert property (@(posedge clk) disable iff (rst)
        capture |=> done)
        else $error("done missing one edge after capture");

    done_needs_capture: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(capture))
        else $error("done without a capture on the previous edge");

endmodule

// File: bench/hv_bundler_tb.sv
`timescale 1ns/10ps
`include "bnd_consts.svh"

module hv_bundler_tb;
    import hdc_types_pkg::*;
    import bundle_ctrl_pkg::*;

    typedef enum logic [1:0] {
        PAT_RANDOM,
        PAT_ONES,
        PAT_ZEROS,
        PAT_TIE
    } pat_t;

    typedef struct packed {
        item_count_t count;
        pat_t        kind;
    } row_t;

    localparam int N_RUNS    = 16;
    localparam int MAX_BEATS = (`BND_MAX_ITEMS + `BND_VOTE_W - 1) / `BND_VOTE_W;
    localparam int TIMEOUT   = 100;

    // item count and vote pattern per run
    localparam row_t RUNS [N_RUNS] = '{
        '{8'd1,   PAT_RANDOM},
        '{8'd33,  PAT_RANDOM},
        '{8'd255, PAT_RANDOM},
        '{8'd5,   PAT_RANDOM},
        '{8'd70,  PAT_RANDOM},
        '{8'd32,  PAT_RANDOM},
        '{8'd64,  PAT_RANDOM},
        '{8'd2,   PAT_TIE},
        '{8'd4,   PAT_TIE},
        '{8'd32,  PAT_TIE},
        '{8'd40,  PAT_TIE},
        '{8'd255, PAT_ONES},
        '{8'd100, PAT_ONES},
        '{8'd7,   PAT_ZEROS},
        '{8'd40,  PAT_ZEROS},
        '{8'd17,  PAT_RANDOM}
    };

    logic        clk;
    logic        rst;
    logic        start;
    item_count_t item_count;
    logic        vote_valid;
    vote_bus_t   votes;
    logic        busy;
    logic        done;
    hv_t         hv_out;

    int          seed = 32'h6f32;
    int          errors;
    int          checks;
    bit          stalled;
    hv_t         model_lfsr;
    vote_bus_t   beat_mem [MAX_BEATS];
    hv_t         last_tie_hv;
    bit          have_tie;
    bit          tie_changed;

    hv_bundler dut_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .item_count (item_count),
        .vote_valid (vote_valid),
        .votes      (votes),
        .busy       (busy),
        .done       (done),
        .hv_out     (hv_out)
    );

    bind bundle_ctrl hv_bundler_asserts asserts_i (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .init    (accept),
        .update  (update),
        .last    (last),
        .capture (capture),
        .done    (hv_bundler_tb.dut_i.done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_hv(input string name, input hv_t got, input hv_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, want);
        end
    endtask

    // sample and drive 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // right-shifting Galois step of the tie generator
    function automatic hv_t lfsr_step(input hv_t s);
        hv_t fb;
        fb = s[0] ? hv_t'(`BND_LFSR_TAPS) : hv_t'(0);
        return (s >> 1) ^ fb;
    endfunction

    task automatic build_beats(input int n, input pat_t kind);
        vote_word_t word;
        int         k;
        for (int b = 0; b < MAX_BEATS; b++) begin
            for (int d = 0; d < `BND_HV_DIM; d++) begin
                // random fill doubles as garbage above the count
                word = $random(seed);
                for (int j = 0; j < `BND_VOTE_W; j++) begin
                    k = b * `BND_VOTE_W + j;
                    if (k < n && kind == PAT_ONES) begin
                        word[j] = 1'b1;
                    end else if (k < n && kind == PAT_ZEROS) begin
                        word[j] = 1'b0;
                    end else if (k < n && kind == PAT_TIE) begin
                        word[j] = ((k + d) % 2) == 1;
                    end
                end
                beat_mem[b][d] = word;
            end
        end
    endtask

    function automatic hv_t expected_hv(input int n, input hv_t tie);
        hv_t result;
        int  sum;
        int  b;
        int  j;
        for (int d = 0; d < `BND_HV_DIM; d++) begin
            // even count starts at +1 for tie bit 0, -1 for tie bit 1
            sum = 0;
            if (n % 2 == 0) begin
                sum = tie[d] ? -1 : 1;
            end
            for (int k = 0; k < n; k++) begin
                b = k / `BND_VOTE_W;
                j = k % `BND_VOTE_W;
                sum += beat_mem[b][d][j] ? 1 : -1;
            end
            result[d] = (sum > 0);
        end
        return result;
    endfunction

    task automatic run_one(input int idx, input row_t row, output bit timed_out);
        int  n;
        int  nbeats;
        int  errs_before;
        int  cycles;
        hv_t tie;
        hv_t want;
        n           = int'(row.count);
        nbeats      = (n + `BND_VOTE_W - 1) / `BND_VOTE_W;
        errs_before = errors;
        timed_out   = 1'b0;
        build_beats(n, row.kind);
        tie  = lfsr_step(model_lfsr);
        want = expected_hv(n, tie);

        // stray beat while idle, held through the start cycle
        vote_valid = 1'b1;
        votes      = ~beat_mem[0];
        next_cycle();
        start      = 1'b1;
        item_count = row.count;
        next_cycle();
        model_lfsr = tie;
        start      = 1'b0;
        check_bit("busy", busy, 1'b1);

        for (int b = 0; b < nbeats; b++) begin
            vote_valid = 1'b1;
            votes      = beat_mem[b];
            // restart attempt with another count while busy
            start      = (b == 0);
            item_count = row.count + 8'd3;
            next_cycle();
            start      = 1'b0;
            vote_valid = 1'b0;
            check_bit("busy", busy, 1'b1);
            check_bit("done", done, 1'b0);
            if (b == 0 && nbeats > 1) begin
                votes = ~beat_mem[b];
                next_cycle();
            end
        end

        cycles = 0;
        while (done !== 1'b1 && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end

        if (done !== 1'b1) begin
            timed_out = 1'b1;
            $display("run %0d: no done within %0d cycles after the last beat", idx, TIMEOUT);
        end else begin
            if (cycles != 1) begin
                errors++;
                $display("run %0d: done came %0d edges after the last beat, not one",
                    idx, cycles);
            end
            check_bit("busy", busy, 1'b0);
            check_hv("hv_out", hv_out, want);
            if (row.kind == PAT_TIE) begin
                if (have_tie && hv_out != last_tie_hv) begin
                    tie_changed = 1'b1;
                end
                last_tie_hv = hv_out;
                have_tie    = 1'b1;
            end
            next_cycle();
            // single done pulse, result held
            check_bit("done", done, 1'b0);
            check_hv("hv_out", hv_out, want);
            $display("run %0d: count %0d %s hv_out %h %s", idx, n, row.kind.name(),
                want, (errors == errs_before) ? "ok" : "mismatch");
        end
    endtask

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        item_count  = '0;
        vote_valid  = 1'b0;
        votes       = '0;
        errors      = 0;
        checks      = 0;
        stalled     = 1'b0;
        have_tie    = 1'b0;
        tie_changed = 1'b0;
        last_tie_hv = '0;
        model_lfsr  = hv_t'(`BND_LFSR_SEED);

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_hv("hv_out", hv_out, hv_t'(0));
        $display("reset: %s", (errors == 0) ? "ok" : "mismatch");

        for (int i = 0; i < N_RUNS; i++) begin
            if (!stalled) begin
                run_one(i, RUNS[i], stalled);
            end
        end

        if (!stalled && !tie_changed) begin
            errors++;
            $display("tie-break result stayed the same over all exact-tie runs");
        end

        $display("runs %0d, checks %0d, errors %0d, timeout %0d",
            N_RUNS, checks, errors, stalled);
        if (errors == 0 && !stalled) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/hdc_types_pkg.sv
design/bundle_ctrl_pkg.sv
design/bundle_ctrl_if.sv
design/bundle_ctrl.sv
design/vote_counter.sv
design/sign_collector.sv
design/hv_bundler.sv
bench/hv_bundler_asserts.sv
bench/hv_bundler_tb.sv

// File: Makefile
TOP := hv_bundler_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
